//--- hw/mem_hier_config.svh
`ifndef MEM_HIER_CONFIG_SVH
`define MEM_HIER_CONFIG_SVH

// memory side widths
`define ADDR_W 32
`define LINE_W 128
`define CNT_W 32
`define FLUSH_CNT_W 16

// wishbone slave
`define WB_DATA_W 32
`define WB_ADR_W 3

// register map, word addresses
`define REG_CTRL 3'd0
`define REG_L1I_ACC 3'd1
`define REG_L1I_HIT 3'd2
`define REG_L1D_ACC 3'd3
`define REG_L1D_HIT 3'd4
`define REG_L1I_GNT 3'd5
`define REG_L1D_GNT 3'd6

`endif

//--- hw/mem_hier_pkg.sv
`include "mem_hier_config.svh"

package mem_hier_pkg;

   typedef logic [`ADDR_W-1:0] mem_addr_t;      // line address
   typedef logic [`LINE_W-1:0] mem_line_t;
   typedef logic [`WB_DATA_W-1:0] wb_word_t;
   typedef logic [`CNT_W-1:0] counter_t;
   typedef logic [`FLUSH_CNT_W-1:0] flush_count_t;

   // memory port opcodes
   typedef enum logic [3:0]
   {
      MEM_LD_LINE = 4'd4,
      MEM_ST_LINE = 4'd7
   } mem_opcode_t;

   // GOT_L1D means l1d is done and l1i is still outstanding
   typedef enum logic [2:0]
   {
      FLUSH_IDLE       = 3'd0,
      WAIT_FOR_L1D_L1I = 3'd1,
      GOT_L1D          = 3'd2,
      GOT_L1I          = 3'd3,
      FLUSH_L2         = 3'd4
   } flush_state_t;

endpackage

//--- hw/flush_ctl_if.sv
`timescale 1ns/1ps

interface flush_ctl_if;
   import mem_hier_pkg::*;

   logic start_l1i;              // one cycle pulses from the register block
   logic start_l1d;
   logic in_flush;
   flush_count_t flush_count;    // completed flushes

   modport regs
   (
      output start_l1i,
      output start_l1d,
      input  in_flush,
      input  flush_count
   );

   modport seq
   (
      input  start_l1i,
      input  start_l1d,
      output in_flush,
      output flush_count
   );
endinterface

//--- hw/flush_sequencer.sv
`timescale 1ns/1ps

module flush_sequencer
(
   input  logic clk,
   input  logic reset,
   flush_ctl_if.seq ctl,
   output logic l1i_flush_req,
   output logic l1d_flush_req,
   output logic l2_flush_req,
   input  logic l1i_flush_done,
   input  logic l1d_flush_done,
   input  logic l2_flush_done
);
   import mem_hier_pkg::*;

   flush_state_t r_state, n_state;
   logic r_flush, n_flush;
   logic n_l1i_req, n_l1d_req, n_l2_req;
   flush_count_t r_count;

   assign ctl.in_flush = r_flush;
   assign ctl.flush_count = r_count;

   always_comb
   begin
      n_state = r_state;
      n_flush = r_flush;
      n_l1i_req = 1'b0;
      n_l1d_req = 1'b0;
      n_l2_req = 1'b0;
      case (r_state)
         FLUSH_IDLE:
         begin
            if (ctl.start_l1i || ctl.start_l1d)
            begin
               n_flush = 1'b1;
               n_l1i_req = ctl.start_l1i;
               n_l1d_req = ctl.start_l1d;
               if (ctl.start_l1i && ctl.start_l1d)
                  n_state = WAIT_FOR_L1D_L1I;
               else if (ctl.start_l1i)
                  n_state = GOT_L1D;  // l1d not selected, counts as done
               else
                  n_state = GOT_L1I;
            end
         end
         WAIT_FOR_L1D_L1I:
         begin
            if (l1d_flush_done && l1i_flush_done)
            begin
               n_state = FLUSH_L2;
               n_l2_req = 1'b1;
            end
            else if (l1d_flush_done)
               n_state = GOT_L1D;
            else if (l1i_flush_done)
               n_state = GOT_L1I;
         end
         GOT_L1D:
         begin
            if (l1i_flush_done)
            begin
               n_state = FLUSH_L2;
               n_l2_req = 1'b1;
            end
         end
         GOT_L1I:
         begin
            if (l1d_flush_done)
            begin
               n_state = FLUSH_L2;
               n_l2_req = 1'b1;
            end
         end
         FLUSH_L2:
         begin
            if (l2_flush_done)
            begin
               n_flush = 1'b0;
               n_state = FLUSH_IDLE;
            end
         end
         default:
            n_state = FLUSH_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= FLUSH_IDLE;
         r_flush <= 1'b0;
         l1i_flush_req <= 1'b0;
         l1d_flush_req <= 1'b0;
         l2_flush_req <= 1'b0;
         r_count <= '0;
      end
      else
      begin
         r_state <= n_state;
         r_flush <= n_flush;
         l1i_flush_req <= n_l1i_req;
         l1d_flush_req <= n_l1d_req;
         l2_flush_req <= n_l2_req;
         if (r_state == FLUSH_L2 && l2_flush_done)
            r_count <= r_count + 1'b1;
      end
   end
endmodule

//--- hw/miss_arbiter.sv
`timescale 1ns/1ps

module miss_arbiter
(
   input  logic clk,
   input  logic reset,
   input  logic in_flush,

   // instruction miss port, loads only
   input  logic l1i_req_valid,
   input  mem_hier_pkg::mem_addr_t l1i_req_addr,
   output logic l1i_rsp_valid,
   output mem_hier_pkg::mem_line_t l1i_rsp_data,

   // data miss port
   input  logic l1d_req_valid,
   input  mem_hier_pkg::mem_addr_t l1d_req_addr,
   input  mem_hier_pkg::mem_opcode_t l1d_req_opcode,
   input  mem_hier_pkg::mem_line_t l1d_req_store_data,
   output logic l1d_rsp_valid,
   output mem_hier_pkg::mem_line_t l1d_rsp_data,

   // shared memory port
   output logic mem_req_valid,
   output mem_hier_pkg::mem_addr_t mem_req_addr,
   output mem_hier_pkg::mem_opcode_t mem_req_opcode,
   output mem_hier_pkg::mem_line_t mem_req_store_data,
   input  logic mem_rsp_valid,
   input  mem_hier_pkg::mem_line_t mem_rsp_load_data,

   output logic l1i_grant,
   output logic l1d_grant
);
   import mem_hier_pkg::*;

   logic busy;
   logic owner_d;        // outstanding request belongs to l1d
   logic grant_ok;
   logic start;
   logic done;
   mem_line_t r_rsp_data;

   // requester still sees its valid in the response cycle, so hold off then
   assign grant_ok = !busy && !in_flush && !l1i_rsp_valid && !l1d_rsp_valid;
   assign start = grant_ok && (l1d_req_valid || l1i_req_valid);
   assign done = busy && mem_rsp_valid;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy <= 1'b0;
         mem_req_valid <= 1'b0;
         l1i_rsp_valid <= 1'b0;
         l1d_rsp_valid <= 1'b0;
      end
      else
      begin
         mem_req_valid <= start;
         l1i_rsp_valid <= done && !owner_d;
         l1d_rsp_valid <= done && owner_d;
         if (start)
            busy <= 1'b1;
         else if (done)
            busy <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         owner_d <= l1d_req_valid;   // data side wins
         if (l1d_req_valid)
         begin
            mem_req_addr <= l1d_req_addr;
            mem_req_opcode <= l1d_req_opcode;
            mem_req_store_data <= l1d_req_store_data;
         end
         else
         begin
            mem_req_addr <= l1i_req_addr;
            mem_req_opcode <= MEM_LD_LINE;
         end
      end
      if (done)
         r_rsp_data <= mem_rsp_load_data;
   end

   assign l1i_rsp_data = r_rsp_data;
   assign l1d_rsp_data = r_rsp_data;

   // one grant per completed transaction
   assign l1i_grant = l1i_rsp_valid;
   assign l1d_grant = l1d_rsp_valid;
endmodule

//--- hw/mem_hier_regs.sv
`timescale 1ns/1ps
`include "mem_hier_config.svh"

module mem_hier_regs
(
   input  logic clk,
   input  logic reset,

   // wishbone classic slave
   input  logic wb_cyc,
   input  logic wb_stb,
   input  logic wb_we,
   input  logic [`WB_ADR_W-1:0] wb_adr,
   input  mem_hier_pkg::wb_word_t wb_dat_w,
   output mem_hier_pkg::wb_word_t wb_dat_r,
   output logic wb_ack,

   // event pulses
   input  logic l1i_access,
   input  logic l1i_hit,
   input  logic l1d_access,
   input  logic l1d_hit,
   input  logic l1i_grant,
   input  logic l1d_grant,

   flush_ctl_if.regs flush
);
   import mem_hier_pkg::*;

   localparam int N_CNT = 6;

   counter_t cnt [N_CNT];
   logic [N_CNT-1:0] ev;
   logic wr;

   // counter i lives at word address i + 1
   assign ev = {l1d_grant, l1i_grant, l1d_hit, l1d_access, l1i_hit, l1i_access};

   // writes land in the ack cycle
   assign wr = wb_ack && wb_cyc && wb_stb && wb_we;

   always_ff @(posedge clk)
   begin
      if (reset)
         wb_ack <= 1'b0;
      else
         wb_ack <= wb_cyc && wb_stb && !wb_ack;
   end

   assign flush.start_l1i = wr && (wb_adr == `REG_CTRL) && wb_dat_w[0];
   assign flush.start_l1d = wr && (wb_adr == `REG_CTRL) && wb_dat_w[1];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < N_CNT; i++)
            cnt[i] <= '0;
      end
      else
      begin
         for (int i = 0; i < N_CNT; i++)
         begin
            if (wr && int'(wb_adr) == i + 1)
               cnt[i] <= '0;   // clear beats a same cycle event
            else if (ev[i])
               cnt[i] <= cnt[i] + 1'b1;
         end
      end
   end

   always_comb
   begin
      wb_dat_r = '0;
      case (wb_adr)
         `REG_CTRL:
         begin
            wb_dat_r = {flush.flush_count,
                        {(`WB_DATA_W - `FLUSH_CNT_W - 1){1'b0}},
                        flush.in_flush};
         end
         `REG_L1I_ACC:
            wb_dat_r = cnt[0];
         `REG_L1I_HIT:
            wb_dat_r = cnt[1];
         `REG_L1D_ACC:
            wb_dat_r = cnt[2];
         `REG_L1D_HIT:
            wb_dat_r = cnt[3];
         `REG_L1I_GNT:
            wb_dat_r = cnt[4];
         `REG_L1D_GNT:
            wb_dat_r = cnt[5];
         default:
            wb_dat_r = '0;   // unmapped
      endcase
   end
endmodule

//--- hw/mem_hier_ctrl.sv
`timescale 1ns/1ps
`include "mem_hier_config.svh"

module mem_hier_ctrl
(
   input  logic clk,
   input  logic reset,

   input  logic wb_cyc,
   input  logic wb_stb,
   input  logic wb_we,
   input  logic [`WB_ADR_W-1:0] wb_adr,
   input  mem_hier_pkg::wb_word_t wb_dat_w,
   output mem_hier_pkg::wb_word_t wb_dat_r,
   output logic wb_ack,

   input  logic l1i_req_valid,
   input  mem_hier_pkg::mem_addr_t l1i_req_addr,
   output logic l1i_rsp_valid,
   output mem_hier_pkg::mem_line_t l1i_rsp_data,

   input  logic l1d_req_valid,
   input  mem_hier_pkg::mem_addr_t l1d_req_addr,
   input  mem_hier_pkg::mem_opcode_t l1d_req_opcode,
   input  mem_hier_pkg::mem_line_t l1d_req_store_data,
   output logic l1d_rsp_valid,
   output mem_hier_pkg::mem_line_t l1d_rsp_data,

   output logic mem_req_valid,
   output mem_hier_pkg::mem_addr_t mem_req_addr,
   output mem_hier_pkg::mem_opcode_t mem_req_opcode,
   output mem_hier_pkg::mem_line_t mem_req_store_data,
   input  logic mem_rsp_valid,
   input  mem_hier_pkg::mem_line_t mem_rsp_load_data,

   output logic l1i_flush_req,
   output logic l1d_flush_req,
   input  logic l1i_flush_done,
   input  logic l1d_flush_done,
   output logic l2_flush_req,
   input  logic l2_flush_done,
   output logic in_flush_mode,

   input  logic l1i_access,
   input  logic l1i_hit,
   input  logic l1d_access,
   input  logic l1d_hit
);

   logic l1i_grant;
   logic l1d_grant;

   flush_ctl_if flush ();

   assign in_flush_mode = flush.in_flush;

   mem_hier_regs regs
   (
      .clk(clk),
      .reset(reset),
      .wb_cyc(wb_cyc),
      .wb_stb(wb_stb),
      .wb_we(wb_we),
      .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w),
      .wb_dat_r(wb_dat_r),
      .wb_ack(wb_ack),
      .l1i_access(l1i_access),
      .l1i_hit(l1i_hit),
      .l1d_access(l1d_access),
      .l1d_hit(l1d_hit),
      .l1i_grant(l1i_grant),
      .l1d_grant(l1d_grant),
      .flush(flush.regs)
   );

   flush_sequencer seq
   (
      .clk(clk),
      .reset(reset),
      .ctl(flush.seq),
      .l1i_flush_req(l1i_flush_req),
      .l1d_flush_req(l1d_flush_req),
      .l2_flush_req(l2_flush_req),
      .l1i_flush_done(l1i_flush_done),
      .l1d_flush_done(l1d_flush_done),
      .l2_flush_done(l2_flush_done)
   );

   // no new grants while a flush is running
   miss_arbiter arb
   (
      .clk(clk),
      .reset(reset),
      .in_flush(flush.in_flush),
      .l1i_req_valid(l1i_req_valid),
      .l1i_req_addr(l1i_req_addr),
      .l1i_rsp_valid(l1i_rsp_valid),
      .l1i_rsp_data(l1i_rsp_data),
      .l1d_req_valid(l1d_req_valid),
      .l1d_req_addr(l1d_req_addr),
      .l1d_req_opcode(l1d_req_opcode),
      .l1d_req_store_data(l1d_req_store_data),
      .l1d_rsp_valid(l1d_rsp_valid),
      .l1d_rsp_data(l1d_rsp_data),
      .mem_req_valid(mem_req_valid),
      .mem_req_addr(mem_req_addr),
      .mem_req_opcode(mem_req_opcode),
      .mem_req_store_data(mem_req_store_data),
      .mem_rsp_valid(mem_rsp_valid),
      .mem_rsp_load_data(mem_rsp_load_data),
      .l1i_grant(l1i_grant),
      .l1d_grant(l1d_grant)
   );
endmodule

//--- test/tb_mem_hier_ctrl.sv
`timescale 1ns/1ps
`include "mem_hier_config.svh"

module tb_mem_hier_ctrl;
   import mem_hier_pkg::*;

   localparam int N_MISS = 300;
   localparam int N_FLUSH = 6;
   localparam int N_TRANS = N_MISS + N_FLUSH * 16 + 40;
   localparam int LIMIT = 40 * N_TRANS + 2000;
   localparam mem_line_t LINE_KEY = 128'h5a5a_c3c3_0f0f_9696_a5a5_3c3c_f0f0_6969;

   logic clk = 1'b0;
   logic reset;
   logic wb_cyc, wb_stb, wb_we, wb_ack;
   logic [`WB_ADR_W-1:0] wb_adr;
   wb_word_t wb_dat_w, wb_dat_r;
   logic l1i_req_valid, l1i_rsp_valid, l1d_req_valid, l1d_rsp_valid;
   mem_addr_t l1i_req_addr, l1d_req_addr, mem_req_addr;
   mem_opcode_t l1d_req_opcode, mem_req_opcode;
   mem_line_t l1d_req_store_data, l1i_rsp_data, l1d_rsp_data;
   mem_line_t mem_req_store_data, mem_rsp_load_data;
   logic mem_req_valid, mem_rsp_valid;
   logic l1i_flush_req, l1d_flush_req, l1i_flush_done, l1d_flush_done;
   logic l2_flush_req, l2_flush_done, in_flush_mode;
   logic l1i_access, l1i_hit, l1d_access, l1d_hit;

   int cycles = 0;
   int i_target = 0, d_target = 0, i_issued = 0, d_issued = 0;
   int i_rsp_cnt = 0, d_rsp_cnt = 0, i_gnt_base = 0, d_gnt_base = 0;
   int ev_cnt [4];
   logic ev_en = 1'b0;
   logic i_seen, d_seen, flush_seen;
   logic out_busy, out_owner_d;
   mem_addr_t out_addr;
   mem_opcode_t out_op;
   mem_line_t mem_store [mem_addr_t];   // lines written by stores
   logic m_busy;
   int m_wait;
   mem_addr_t m_addr;
   mem_opcode_t m_op;
   logic sel_i = 1'b0, sel_d = 1'b0, got_i, got_d, slow = 1'b0;
   logic fi_busy, fd_busy, f2_busy;
   int fi_wait, fd_wait, f2_wait;

   mem_hier_ctrl UUT (.*);

   always #2 clk = ~clk;

   function automatic mem_line_t model_line(mem_addr_t a);
      return {4{a}} ^ LINE_KEY;
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("FAIL: see errors above");
      $fatal(1, "run stopped");
   endtask

   task automatic check_word(input string name, input wb_word_t got, input wb_word_t exp);
      if (got !== exp)
         fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_line(input string name, input mem_line_t got, input mem_line_t exp);
      if (got !== exp)
         fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
      if (got !== exp)
         fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
   endtask

   // one classic cycle, returns the read data seen with ack
   task automatic wb_access(input logic we, input int adr, input wb_word_t wdat,
                            output wb_word_t rdat);
      int n;
      @(posedge clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we <= we;
      wb_adr <= adr[`WB_ADR_W-1:0];
      wb_dat_w <= wdat;
      n = 0;
      do
      begin
         @(posedge clk);
         n++;
         if (n > 4)
            fail_run("wishbone cycle got no ack");
      end while (!wb_ack);
      rdat = wb_dat_r;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we <= 1'b0;
   endtask

   task automatic wait_misses();
      while (i_rsp_cnt < i_target || d_rsp_cnt < d_target)
         @(posedge clk);
   endtask

   task automatic check_counters();
      wb_word_t rd;
      wb_access(1'b0, `REG_L1I_ACC, '0, rd);
      check_word("l1i_acc", rd, wb_word_t'(ev_cnt[0]));
      wb_access(1'b0, `REG_L1I_HIT, '0, rd);
      check_word("l1i_hit", rd, wb_word_t'(ev_cnt[1]));
      wb_access(1'b0, `REG_L1D_ACC, '0, rd);
      check_word("l1d_acc", rd, wb_word_t'(ev_cnt[2]));
      wb_access(1'b0, `REG_L1D_HIT, '0, rd);
      check_word("l1d_hit", rd, wb_word_t'(ev_cnt[3]));
      wb_access(1'b0, `REG_L1I_GNT, '0, rd);
      check_word("l1i_gnt", rd, wb_word_t'(i_rsp_cnt - i_gnt_base));
      wb_access(1'b0, `REG_L1D_GNT, '0, rd);
      check_word("l1d_gnt", rd, wb_word_t'(d_rsp_cnt - d_gnt_base));
   endtask

   always @(posedge clk)
   begin
      cycles++;
      if (cycles > LIMIT)
         fail_run("timeout, the run did not finish in time");
   end

   // miss requesters
   always @(posedge clk)
   begin
      if (l1i_req_valid)
      begin
         if (l1i_rsp_valid)
            l1i_req_valid <= 1'b0;
      end
      else if (!reset && i_issued < i_target && $urandom % 4 == 0)
      begin
         l1i_req_valid <= 1'b1;
         l1i_req_addr <= $urandom;
         i_issued++;
      end
      if (l1d_req_valid)
      begin
         if (l1d_rsp_valid)
            l1d_req_valid <= 1'b0;
      end
      else if (!reset && d_issued < d_target && $urandom % 4 == 0)
      begin
         l1d_req_valid <= 1'b1;
         l1d_req_addr <= $urandom;
         l1d_req_opcode <= ($urandom % 2 == 0) ? MEM_LD_LINE : MEM_ST_LINE;
         l1d_req_store_data <= {$urandom, $urandom, $urandom, $urandom};
         d_issued++;
      end
   end

   // grant and response monitor
   always @(posedge clk)
   begin
      i_seen <= l1i_req_valid;    // what the arbiter saw at this edge
      d_seen <= l1d_req_valid;
      flush_seen <= in_flush_mode;
      if (reset)
         out_busy <= 1'b0;
      else
      begin
         if (mem_req_valid)
         begin
            if (out_busy)
               fail_run("second memory request while one is outstanding");
            if (flush_seen)
               fail_run("memory request granted during a flush");
            if (d_seen)
            begin
               check_addr("mem_req_addr", mem_req_addr, l1d_req_addr);
               check_word("mem_req_opcode", wb_word_t'(mem_req_opcode),
                          wb_word_t'(l1d_req_opcode));
               if (l1d_req_opcode == MEM_ST_LINE)
                  check_line("mem_req_store_data", mem_req_store_data, l1d_req_store_data);
            end
            else if (i_seen)
            begin
               check_addr("mem_req_addr", mem_req_addr, l1i_req_addr);
               check_word("mem_req_opcode", wb_word_t'(mem_req_opcode),
                          wb_word_t'(MEM_LD_LINE));
            end
            else
               fail_run("memory request with no miss pending");
            out_busy <= 1'b1;
            out_owner_d <= d_seen;
            out_addr <= mem_req_addr;
            out_op <= mem_req_opcode;
         end
         if (l1i_rsp_valid)
         begin
            if (!out_busy || out_owner_d)
               fail_run("unexpected response on the l1i port");
            check_line("l1i_rsp_data", l1i_rsp_data, model_line(out_addr));
            i_rsp_cnt <= i_rsp_cnt + 1;
            out_busy <= 1'b0;
         end
         if (l1d_rsp_valid)
         begin
            if (!out_busy || !out_owner_d)
               fail_run("unexpected response on the l1d port");
            if (out_op == MEM_LD_LINE)
               check_line("l1d_rsp_data", l1d_rsp_data, model_line(out_addr));
            else
               check_line("mem_req_store_data", mem_store[out_addr], l1d_req_store_data);
            d_rsp_cnt <= d_rsp_cnt + 1;
            out_busy <= 1'b0;
         end
      end
   end

   // memory, answers after 1 to 8 cycles
   always @(posedge clk)
   begin
      if (reset)
      begin
         mem_rsp_valid <= 1'b0;
         m_busy = 1'b0;
      end
      else
      begin
         mem_rsp_valid <= 1'b0;
         if (m_busy)
         begin
            if (m_wait == 0)
            begin
               mem_rsp_valid <= 1'b1;
               if (m_op == MEM_LD_LINE)
                  mem_rsp_load_data <= model_line(m_addr);
               else
                  mem_rsp_load_data <= {$urandom, $urandom, $urandom, $urandom};
               m_busy = 1'b0;
            end
            else
               m_wait--;
         end
         if (mem_req_valid)
         begin
            m_busy = 1'b1;
            m_wait = $urandom % 8;
            m_addr = mem_req_addr;
            m_op = mem_req_opcode;
            if (mem_req_opcode == MEM_ST_LINE)
               mem_store[mem_req_addr] = mem_req_store_data;
         end
      end
   end

   // L1 and L2 flush responders
   always @(posedge clk)
   begin
      if (reset)
      begin
         l1i_flush_done <= 1'b0;
         l1d_flush_done <= 1'b0;
         l2_flush_done <= 1'b0;
         fi_busy = 1'b0;
         fd_busy = 1'b0;
         f2_busy = 1'b0;
      end
      else
      begin
         l1i_flush_done <= 1'b0;
         l1d_flush_done <= 1'b0;
         l2_flush_done <= 1'b0;
         if (l1i_flush_done)
            got_i = 1'b1;
         if (l1d_flush_done)
            got_d = 1'b1;
         if (l2_flush_done)
            check_bit("in_flush_mode", in_flush_mode, 1'b1);
         if (l1i_flush_req)
         begin
            if (!sel_i)
               fail_run("l1i flush request without a selected l1i flush");
            check_bit("in_flush_mode", in_flush_mode, 1'b1);
            fi_busy = 1'b1;
            fi_wait = slow ? 10 : $urandom % 11;
         end
         else if (fi_busy)
         begin
            if (fi_wait == 0)
            begin
               l1i_flush_done <= 1'b1;
               fi_busy = 1'b0;
            end
            else
               fi_wait--;
         end
         if (l1d_flush_req)
         begin
            if (!sel_d)
               fail_run("l1d flush request without a selected l1d flush");
            check_bit("in_flush_mode", in_flush_mode, 1'b1);
            fd_busy = 1'b1;
            fd_wait = slow ? 10 : $urandom % 11;
         end
         else if (fd_busy)
         begin
            if (fd_wait == 0)
            begin
               l1d_flush_done <= 1'b1;
               fd_busy = 1'b0;
            end
            else
               fd_wait--;
         end
         if (l2_flush_req)
         begin
            if ((sel_i && !got_i) || (sel_d && !got_d))
               fail_run("l2 flush requested before the selected L1 flushes were done");
            f2_busy = 1'b1;
            f2_wait = $urandom % 6;
         end
         else if (f2_busy)
         begin
            if (f2_wait == 0)
            begin
               l2_flush_done <= 1'b1;
               f2_busy = 1'b0;
            end
            else
               f2_wait--;
         end
      end
   end

   // random cache events, counted as sampled
   always @(posedge clk)
   begin
      if (!reset)
      begin
         if (l1i_access)
            ev_cnt[0]++;
         if (l1i_hit)
            ev_cnt[1]++;
         if (l1d_access)
            ev_cnt[2]++;
         if (l1d_hit)
            ev_cnt[3]++;
      end
      if (ev_en)
         {l1i_access, l1i_hit, l1d_access, l1d_hit} <= 4'($urandom);
      else
         {l1i_access, l1i_hit, l1d_access, l1d_hit} <= 4'b0;
   end

   initial
   begin
      wb_word_t rd;
      int sel;
      int n_flush;
      void'($urandom(32'h48323d0d));
      n_flush = 0;
      for (int i = 0; i < 4; i++)
         ev_cnt[i] = 0;
      reset = 1'b1;
      {wb_cyc, wb_stb, wb_we} = 3'b0;
      wb_adr = '0;
      wb_dat_w = '0;
      l1i_req_valid = 1'b0;
      l1i_req_addr = '0;
      l1d_req_valid = 1'b0;
      l1d_req_addr = '0;
      l1d_req_opcode = MEM_LD_LINE;
      l1d_req_store_data = '0;
      mem_rsp_valid = 1'b0;
      mem_rsp_load_data = '0;
      {l1i_flush_done, l1d_flush_done, l2_flush_done} = 3'b0;
      {l1i_access, l1i_hit, l1d_access, l1d_hit} = 4'b0;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);

      check_bit("in_flush_mode", in_flush_mode, 1'b0);
      check_bit("mem_req_valid", mem_req_valid, 1'b0);
      check_bit("l1i_rsp_valid", l1i_rsp_valid, 1'b0);
      check_bit("l1d_rsp_valid", l1d_rsp_valid, 1'b0);
      check_bit("l1i_flush_req", l1i_flush_req, 1'b0);
      check_bit("l1d_flush_req", l1d_flush_req, 1'b0);
      check_bit("l2_flush_req", l2_flush_req, 1'b0);
      check_bit("wb_ack", wb_ack, 1'b0);
      for (int a = 0; a < 8; a++)
      begin
         wb_access(1'b0, a, '0, rd);
         check_word($sformatf("reg %0d after reset", a), rd, '0);
      end

      // misses on both ports with events running
      ev_en = 1'b1;
      i_target = N_MISS / 2;
      d_target = N_MISS / 2;
      wait_misses();
      ev_en = 1'b0;
      repeat (3) @(posedge clk);
      check_counters();
      for (int a = 1; a <= 6; a++)
      begin
         wb_access(1'b1, a, 32'hffff_ffff, rd);
         wb_access(1'b0, a, '0, rd);
         check_word($sformatf("reg %0d after clear", a), rd, '0);
      end
      for (int i = 0; i < 4; i++)
         ev_cnt[i] = 0;
      i_gnt_base = i_rsp_cnt;
      d_gnt_base = d_rsp_cnt;

      // flushes, with misses arriving around them
      for (int k = 0; k < N_FLUSH; k++)
      begin
         sel = 1 + $urandom % 3;
         slow = (k % 2 == 1);
         sel_i = sel[0];
         sel_d = sel[1];
         got_i = 1'b0;
         got_d = 1'b0;
         i_target += 5;
         d_target += 5;
         wb_access(1'b1, `REG_CTRL, wb_word_t'(sel), rd);
         if (slow)
         begin
            wb_access(1'b0, `REG_CTRL, '0, rd);
            check_bit("ctrl in_flush", rd[0], 1'b1);
            wb_access(1'b1, `REG_CTRL, wb_word_t'(1 + $urandom % 3), rd);
         end
         wb_access(1'b1, `REG_CTRL, '0, rd);   // no bits set, ignored
         while (in_flush_mode)
            @(posedge clk);
         wb_access(1'b1, `REG_CTRL, '0, rd);   // idle again, still no start
         n_flush++;
         wb_access(1'b0, `REG_CTRL, '0, rd);
         check_word("ctrl", rd, {n_flush[15:0], 16'h0000});
         sel_i = 1'b0;
         sel_d = 1'b0;
         slow = 1'b0;
      end
      wait_misses();
      repeat (3) @(posedge clk);
      check_counters();

      $display("PASS: all tests");
      $finish;
   end
endmodule

//--- build.f
+incdir+hw
hw/mem_hier_pkg.sv
hw/flush_ctl_if.sv
hw/flush_sequencer.sv
hw/miss_arbiter.sv
hw/mem_hier_regs.sv
hw/mem_hier_ctrl.sv
test/tb_mem_hier_ctrl.sv

//--- Makefile
TOP := tb_mem_hier_ctrl

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Ihw --top-module $(TOP) -f build.f
	verilator --lint-only -Ihw --top-module mem_hier_ctrl \
		hw/mem_hier_pkg.sv hw/flush_ctl_if.sv hw/flush_sequencer.sv \
		hw/miss_arbiter.sv hw/mem_hier_regs.sv hw/mem_hier_ctrl.sv

sim:
	verilator --binary --timing -Ihw --top-module $(TOP) -f build.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
